// ==== meta_pkg.sv ====
package meta_pkg;

    ////////////////////
    // tag and table sizing

    // default number of tags in flight
    localparam int MAX_IDS = 8;

    // tag of an instruction in flight, 3 bits covers the default table
    typedef logic [2:0] id_t;

    // redirect epoch, wraps on overflow
    typedef logic [3:0] epoch_t;

    ////////////////////
    // configuration space

    // register select for config writes
    typedef enum logic [0:0] {
        CFG_START_PC = 1'b0,
        CFG_ENABLE   = 1'b1
    } cfg_addr_e;

    ////////////////////
    // opcode classes

    // coarse class of the major opcode, bits 6 to 0
    typedef enum logic [2:0] {
        OP_BRANCH = 3'd0,
        OP_JAL    = 3'd1,
        OP_JALR   = 3'd2,
        OP_LOAD   = 3'd3,
        OP_STORE  = 3'd4,
        OP_OTHER  = 3'd5
    } op_class_e;

    // rv32 major opcodes
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

endpackage

// ==== fetch_config.sv ====
`timescale 1ns/1ps

module fetch_config (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cfg_wr,
    input  meta_pkg::cfg_addr_e cfg_addr,
    input  logic [31:0]         cfg_wdata,
    output logic [31:0]         start_pc,
    output logic                start_load,
    output logic                fetch_enable
);

    ////////////////////
    // register decode

    // write hits the start pc register
    logic wr_start_pc;
    // write hits the enable register
    logic wr_enable;

    assign wr_start_pc = cfg_wr && (cfg_addr == meta_pkg::CFG_START_PC);
    assign wr_enable   = cfg_wr && (cfg_addr == meta_pkg::CFG_ENABLE);

    ////////////////////
    // config registers

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_pc     <= '0;
            fetch_enable <= 1'b0;
            start_load   <= 1'b0;
        end else begin
            // new start pc, captured at the write edge
            if (wr_start_pc) begin
                start_pc <= cfg_wdata;
            end
            // only bit 0 of the enable word matters
            if (wr_enable) begin
                fetch_enable <= cfg_wdata[0];
            end
            // one cycle pulse so pc_gen reloads from start_pc
            start_load <= wr_start_pc;
        end
    end

endmodule

// ==== id_pool.sv ====
`timescale 1ns/1ps

module id_pool #(
    parameter int num_ids = meta_pkg::MAX_IDS
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          id_alloc,
    input  logic          retire,
    input  meta_pkg::id_t retire_id,
    output meta_pkg::id_t next_id,
    output logic          id_available
);

    // pointer and occupancy widths follow the pool size
    localparam int ptr_w = (num_ids > 1) ? $clog2(num_ids) : 1;
    localparam int cnt_w = $clog2(num_ids + 1);

    ////////////////////
    // free list storage

    meta_pkg::id_t    free_list [num_ids];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;

    // effective pop and push this cycle
    logic pop;
    logic push;

    // pop only when something is there
    assign pop  = id_alloc && id_available;
    assign push = retire;

    // head of the list is the tag handed out next
    assign next_id      = free_list[rd_ptr];
    assign id_available = (count != '0);

    ////////////////////
    // pointers and count

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // list starts full, write pointer wraps back onto slot 0
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= cnt_w'(num_ids);
            for (int i = 0; i < num_ids; i++) begin
                free_list[i] <= meta_pkg::id_t'(i);
            end
        end else begin
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // released tag goes on the tail
            if (push) begin
                free_list[wr_ptr] <= retire_id;
                wr_ptr            <= wr_ptr + 1'b1;
            end
            // simultaneous pop and push leaves count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== pc_gen.sv ====
`timescale 1ns/1ps

module pc_gen (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             fetch_enable,
    input  logic [31:0]      start_pc,
    input  logic             start_load,
    input  logic             redirect,
    input  logic [31:0]      redirect_pc,
    input  logic             id_available,
    input  meta_pkg::id_t    next_id,
    output logic             id_alloc,
    output logic             fetch_req,
    output logic [31:0]      fetch_pc,
    output meta_pkg::id_t    fetch_id,
    output meta_pkg::epoch_t fetch_epoch
);

    ////////////////////
    // pc state

    // pc of the next request
    logic [31:0]      next_pc;
    // current redirect epoch
    meta_pkg::epoch_t epoch;
    // pc reload this cycle, either source
    logic             reload;
    // a request goes out at this edge
    logic             issue;

    assign reload = redirect || start_load;

    // no issue while reloading, the new pc goes out one cycle later
    assign issue    = fetch_enable && id_available && !reload;
    // pop the head tag in the same cycle
    assign id_alloc = issue;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            next_pc   <= '0;
            epoch     <= '0;
            fetch_req <= 1'b0;
        end else begin
            fetch_req <= issue;
            // redirect has priority over start_load
            if (redirect) begin
                next_pc <= redirect_pc;
                epoch   <= epoch + 1'b1;
            end else if (start_load) begin
                next_pc <= start_pc;
            end else if (issue) begin
                // sequential fetch
                next_pc <= next_pc + 32'd4;
            end
        end
    end

    ////////////////////
    // request payload

    // only meaningful while fetch_req is high
    always_ff @(posedge clk) begin
        if (issue) begin
            fetch_pc    <= next_pc;
            fetch_id    <= next_id;
            fetch_epoch <= epoch;
        end
    end

endmodule

// ==== instruction_metadata.sv ====
`timescale 1ns/1ps

module instruction_metadata #(
    parameter int num_ids = meta_pkg::MAX_IDS
) (
    input  logic             clk,
    // tag assignment from fetch
    input  logic             pc_id_assigned,
    input  meta_pkg::id_t    pc_id,
    input  logic [31:0]      if_pc,
    input  meta_pkg::epoch_t branch_epoch_if,
    // memory response
    input  logic             fetch_complete,
    input  meta_pkg::id_t    fetch_resp_id,
    input  logic [31:0]      fetch_instruction,
    // decode read port
    input  meta_pkg::id_t    decode_id,
    output logic [31:0]      decode_pc_raw,
    output logic [31:0]      decode_instruction_raw,
    // branch read port
    input  meta_pkg::id_t    branch_id,
    output meta_pkg::epoch_t branch_epoch
);

    // index width for the tables
    localparam int idx_w = (num_ids > 1) ? $clog2(num_ids) : 1;

    ////////////////////
    // tag indexed tables

    logic [31:0]      pc_tbl    [num_ids];
    logic [31:0]      instr_tbl [num_ids];
    meta_pkg::epoch_t epoch_tbl [num_ids];

    // pc and epoch recorded when the tag is handed out
    always_ff @(posedge clk) begin
        if (pc_id_assigned) begin
            pc_tbl[pc_id[idx_w-1:0]]    <= if_pc;
            epoch_tbl[pc_id[idx_w-1:0]] <= branch_epoch_if;
        end
    end

    // instruction word lands whenever memory returns it, any order
    always_ff @(posedge clk) begin
        if (fetch_complete) begin
            instr_tbl[fetch_resp_id[idx_w-1:0]] <= fetch_instruction;
        end
    end

    ////////////////////
    // read ports

    // decode lookup
    assign decode_pc_raw          = pc_tbl[decode_id[idx_w-1:0]];
    assign decode_instruction_raw = instr_tbl[decode_id[idx_w-1:0]];

    // branch metadata lookup
    assign branch_epoch = epoch_tbl[branch_id[idx_w-1:0]];

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                decode_req,
    input  meta_pkg::id_t       decode_id_in,
    output meta_pkg::id_t       decode_id,
    input  logic [31:0]         decode_pc_raw,
    input  logic [31:0]         decode_instruction_raw,
    output logic                decode_valid,
    output logic [31:0]         decode_pc,
    output logic [31:0]         decode_instruction,
    output meta_pkg::op_class_e decode_op
);

    // class of the word read this cycle
    meta_pkg::op_class_e op_class;

    // tag straight to the table read port
    assign decode_id = decode_id_in;

    ////////////////////
    // opcode classification

    always_comb begin
        case (decode_instruction_raw[6:0])
            meta_pkg::OPC_BRANCH: op_class = meta_pkg::OP_BRANCH;
            meta_pkg::OPC_JAL:    op_class = meta_pkg::OP_JAL;
            meta_pkg::OPC_JALR:   op_class = meta_pkg::OP_JALR;
            meta_pkg::OPC_LOAD:   op_class = meta_pkg::OP_LOAD;
            meta_pkg::OPC_STORE:  op_class = meta_pkg::OP_STORE;
            // alu, system and anything unknown
            default:              op_class = meta_pkg::OP_OTHER;
        endcase
    end

    ////////////////////
    // output registers

    // valid strobe, one cycle after the request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            decode_valid <= 1'b0;
        end else begin
            decode_valid <= decode_req;
        end
    end

    // lookup results, held until the next request
    always_ff @(posedge clk) begin
        if (decode_req) begin
            decode_pc          <= decode_pc_raw;
            decode_instruction <= decode_instruction_raw;
            decode_op          <= op_class;
        end
    end

endmodule

// ==== frontend_top.sv ====
`timescale 1ns/1ps

module frontend_top #(
    parameter int num_ids = meta_pkg::MAX_IDS
) (
    input  logic                clk,
    input  logic                rst_n,
    // config writes
    input  logic                cfg_wr,
    input  meta_pkg::cfg_addr_e cfg_addr,
    input  logic [31:0]         cfg_wdata,
    // fetch request to memory
    output logic                fetch_req,
    output logic [31:0]         fetch_pc,
    output meta_pkg::id_t       fetch_id,
    // memory response
    input  logic                fetch_complete,
    input  meta_pkg::id_t       fetch_resp_id,
    input  logic [31:0]         fetch_instruction,
    // redirect from branch resolution
    input  logic                redirect,
    input  logic [31:0]         redirect_pc,
    // decode lookup
    input  logic                decode_req,
    input  meta_pkg::id_t       decode_id,
    output logic                decode_valid,
    output logic [31:0]         decode_pc,
    output logic [31:0]         decode_instruction,
    output meta_pkg::op_class_e decode_op,
    // branch metadata lookup
    input  meta_pkg::id_t       branch_id,
    output meta_pkg::epoch_t    branch_epoch,
    // retire
    input  logic                retire,
    input  meta_pkg::id_t       retire_id
);

    ////////////////////
    // internal wires

    logic [31:0]      start_pc;
    logic             start_load;
    logic             fetch_enable;
    logic             id_alloc;
    logic             id_available;
    meta_pkg::id_t    next_id;
    meta_pkg::epoch_t fetch_epoch;
    meta_pkg::id_t    table_decode_id;
    logic [31:0]      decode_pc_raw;
    logic [31:0]      decode_instruction_raw;

    fetch_config cfg_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_wr       (cfg_wr),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .start_pc     (start_pc),
        .start_load   (start_load),
        .fetch_enable (fetch_enable)
    );

    id_pool #(
        .num_ids (num_ids)
    ) pool_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .id_alloc     (id_alloc),
        .retire       (retire),
        .retire_id    (retire_id),
        .next_id      (next_id),
        .id_available (id_available)
    );

    pc_gen pc_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_enable (fetch_enable),
        .start_pc     (start_pc),
        .start_load   (start_load),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .id_available (id_available),
        .next_id      (next_id),
        .id_alloc     (id_alloc),
        .fetch_req    (fetch_req),
        .fetch_pc     (fetch_pc),
        .fetch_id     (fetch_id),
        .fetch_epoch  (fetch_epoch)
    );

    // the registered request doubles as the tag assignment strobe
    instruction_metadata #(
        .num_ids (num_ids)
    ) meta_i (
        .clk                    (clk),
        .pc_id_assigned         (fetch_req),
        .pc_id                  (fetch_id),
        .if_pc                  (fetch_pc),
        .branch_epoch_if        (fetch_epoch),
        .fetch_complete         (fetch_complete),
        .fetch_resp_id          (fetch_resp_id),
        .fetch_instruction      (fetch_instruction),
        .decode_id              (table_decode_id),
        .decode_pc_raw          (decode_pc_raw),
        .decode_instruction_raw (decode_instruction_raw),
        .branch_id              (branch_id),
        .branch_epoch           (branch_epoch)
    );

    decode_stage dec_i (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .decode_req             (decode_req),
        .decode_id_in           (decode_id),
        .decode_id              (table_decode_id),
        .decode_pc_raw          (decode_pc_raw),
        .decode_instruction_raw (decode_instruction_raw),
        .decode_valid           (decode_valid),
        .decode_pc              (decode_pc),
        .decode_instruction     (decode_instruction),
        .decode_op              (decode_op)
    );

endmodule

// ==== tb_frontend.sv ====
`timescale 1ns/1ps

module tb_frontend;

    localparam int num_ids = meta_pkg::MAX_IDS;
    // cycles an expect_fetch waits for the next request
    localparam int fetch_wait = 20;

    ////////////////////
    // dut signals

    logic                clk = 1'b0;
    logic                rst_n;
    logic                cfg_wr;
    meta_pkg::cfg_addr_e cfg_addr;
    logic [31:0]         cfg_wdata;
    logic                fetch_req;
    logic [31:0]         fetch_pc;
    meta_pkg::id_t       fetch_id;
    logic                fetch_complete;
    meta_pkg::id_t       fetch_resp_id;
    logic [31:0]         fetch_instruction;
    logic                redirect;
    logic [31:0]         redirect_pc;
    logic                decode_req;
    meta_pkg::id_t       decode_id;
    logic                decode_valid;
    logic [31:0]         decode_pc;
    logic [31:0]         decode_instruction;
    meta_pkg::op_class_e decode_op;
    meta_pkg::id_t       branch_id;
    meta_pkg::epoch_t    branch_epoch;
    logic                retire;
    meta_pkg::id_t       retire_id;

    // stimulus lines without comments
    string       stim_lines [$];
    string       raw_line;
    string       cmd;
    int          fd;
    int          line_idx;
    int          test_no;
    int          cur_test;
    logic [31:0] arg0;
    logic [31:0] arg1;
    logic [31:0] arg2;
    logic [31:0] arg3;
    int          pass_count;
    int          fail_count;
    int          test_checks;
    int          test_errors;

    // memory model request log
    logic [31:0]   req_pc_q [$];
    meta_pkg::id_t req_id_q [$];
    logic          tag_issued [num_ids];

    // decode_req as seen at the last rising edge
    logic          decode_req_seen;

    frontend_top #(
        .num_ids (num_ids)
    ) dut_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .cfg_wr             (cfg_wr),
        .cfg_addr           (cfg_addr),
        .cfg_wdata          (cfg_wdata),
        .fetch_req          (fetch_req),
        .fetch_pc           (fetch_pc),
        .fetch_id           (fetch_id),
        .fetch_complete     (fetch_complete),
        .fetch_resp_id      (fetch_resp_id),
        .fetch_instruction  (fetch_instruction),
        .redirect           (redirect),
        .redirect_pc        (redirect_pc),
        .decode_req         (decode_req),
        .decode_id          (decode_id),
        .decode_valid       (decode_valid),
        .decode_pc          (decode_pc),
        .decode_instruction (decode_instruction),
        .decode_op          (decode_op),
        .branch_id          (branch_id),
        .branch_epoch       (branch_epoch),
        .retire             (retire),
        .retire_id          (retire_id)
    );

    // 4 ns period
    always #2 clk = ~clk;

    ////////////////////
    // memory model

    // sees the value held during the cycle that this edge closes
    always @(posedge clk) begin
        if (rst_n && fetch_req) begin
            req_pc_q.push_back(fetch_pc);
            req_id_q.push_back(fetch_id);
            tag_issued[fetch_id] = 1'b1;
        end
    end

    ////////////////////
    // check helpers

    task automatic compare_hex(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        test_checks++;
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h (stimulus entry %0d)",
                     name, got, exp, line_idx + 1);
            fail_count++;
            test_errors++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("failure at stimulus entry %0d: %s", line_idx + 1, msg);
        test_checks++;
        test_errors++;
        fail_count++;
    endtask

    // one summary line per finished test
    task automatic close_test();
        $display("test %0d %s: %0d checks, %0d errors", cur_test,
                 (test_errors == 0) ? "ok" : "FAILED", test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    ////////////////////
    // decode timing monitor

    always @(posedge clk) begin
        decode_req_seen <= decode_req;
    end

    // valid must be exactly the request of the cycle before
    always @(negedge clk) begin
        if (decode_valid !== decode_req_seen) begin
            report_failure("decode_valid differs from decode_req one cycle earlier");
        end
    end

    ////////////////////
    // command execution from a falling edge

    task automatic run_command();
        int waited;
        waited = 0;
        case (cmd)
            "cfg": begin
                cfg_wr    = 1'b1;
                cfg_addr  = meta_pkg::cfg_addr_e'(arg0[0]);
                cfg_wdata = arg1;
                @(negedge clk);
                cfg_wr = 1'b0;
            end
            "expect_fetch": begin
                // requests keep coming while tags are free
                while (req_pc_q.size() == 0 && waited < fetch_wait) begin
                    @(negedge clk);
                    waited++;
                end
                if (req_pc_q.size() == 0) begin
                    report_failure("no fetch request arrived in time");
                end else begin
                    compare_hex("fetch_pc", req_pc_q.pop_front(), arg0);
                    compare_hex("fetch_id", req_id_q.pop_front(), arg1);
                end
            end
            "respond": begin
                if (!tag_issued[arg0[2:0]]) begin
                    report_failure("memory response for a tag that was never requested");
                end
                fetch_complete    = 1'b1;
                fetch_resp_id     = arg0[2:0];
                fetch_instruction = arg1;
                @(negedge clk);
                fetch_complete = 1'b0;
            end
            "decode": begin
                decode_req = 1'b1;
                decode_id  = arg0[2:0];
                @(negedge clk);
                decode_req = 1'b0;
                // result due exactly one cycle after the request
                if (decode_valid !== 1'b1) begin
                    report_failure("decode_valid did not follow decode_req by one cycle");
                end else begin
                    compare_hex("decode_pc", decode_pc, arg1);
                    compare_hex("decode_instruction", decode_instruction, arg2);
                    compare_hex("decode_op", decode_op, arg3);
                end
            end
            "branch": begin
                branch_id = arg0[2:0];
                @(negedge clk);
                compare_hex("branch_epoch", branch_epoch, arg1);
            end
            "redirect": begin
                redirect    = 1'b1;
                redirect_pc = arg0;
                @(negedge clk);
                redirect = 1'b0;
            end
            "retire": begin
                retire    = 1'b1;
                retire_id = arg0[2:0];
                @(negedge clk);
                retire = 1'b0;
            end
            "idle": begin
                repeat (arg0) @(negedge clk);
                // requests nobody expected yet
                compare_hex("pending fetch requests", req_pc_q.size(), arg1);
            end
            default: report_failure({"unknown stimulus command ", cmd});
        endcase
    endtask

    ////////////////////
    // watchdog

    initial begin
        #1;
        #(stim_lines.size() * 20 * 4);
        $display("watchdog: stimulus stalled at entry %0d and the run never finished",
                 line_idx + 1);
        $display("sim failed");
        $finish;
    end

    ////////////////////
    // main sequence

    initial begin
        rst_n             = 1'b0;
        cfg_wr            = 1'b0;
        cfg_addr          = meta_pkg::CFG_START_PC;
        cfg_wdata         = '0;
        fetch_complete    = 1'b0;
        fetch_resp_id     = '0;
        fetch_instruction = '0;
        redirect          = 1'b0;
        redirect_pc       = '0;
        decode_req        = 1'b0;
        decode_id         = '0;
        branch_id         = '0;
        retire            = 1'b0;
        retire_id         = '0;
        pass_count        = 0;
        fail_count        = 0;
        test_checks       = 0;
        test_errors       = 0;
        cur_test          = 0;
        line_idx          = 0;
        for (int i = 0; i < num_ids; i++) begin
            tag_issued[i] = 1'b0;
        end

        fd = $fopen("frontend_stimulus.txt", "r");
        if (fd == 0) begin
            report_failure("cannot open frontend_stimulus.txt");
        end else begin
            while ($fgets(raw_line, fd)) begin
                // skip blank and comment lines
                if (raw_line.len() > 1 && raw_line.getc(0) != "#") begin
                    stim_lines.push_back(raw_line);
                end
            end
            $fclose(fd);
        end

        // 5 cycle reset released on a falling edge
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (line_idx = 0; line_idx < stim_lines.size(); line_idx++) begin
            arg0 = '0;
            arg1 = '0;
            arg2 = '0;
            arg3 = '0;
            void'($sscanf(stim_lines[line_idx], "%d %s %h %h %h %h",
                          test_no, cmd, arg0, arg1, arg2, arg3));
            if (test_no != cur_test) begin
                if (cur_test != 0) begin
                    close_test();
                end
                cur_test = test_no;
            end
            run_command();
        end
        if (cur_test != 0) begin
            close_test();
        end

        $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== frontend_stimulus.txt ====
# columns: test number (decimal), command, then arguments in hex
# cfg addr data | expect_fetch pc tag | respond tag word | decode tag pc word op
# branch tag epoch | redirect pc | retire tag | idle cycles pending_requests
1 cfg 0 00001000
1 cfg 1 00000001
1 expect_fetch 00001000 0
1 expect_fetch 00001004 1
1 expect_fetch 00001008 2
2 expect_fetch 0000100c 3
2 expect_fetch 00001010 4
2 expect_fetch 00001014 5
2 expect_fetch 00001018 6
2 expect_fetch 0000101c 7
2 idle 8 0
3 respond 3 00008067
3 respond 0 00000013
3 respond 5 00b2a023
3 respond 1 00c58063
3 respond 4 0002a303
3 respond 2 008000ef
3 decode 1 00001004 00c58063 0
3 decode 3 0000100c 00008067 2
3 decode 0 00001000 00000013 5
3 decode 5 00001014 00b2a023 4
3 decode 2 00001008 008000ef 1
3 decode 4 00001010 0002a303 3
4 redirect 00002000
4 retire 2
4 expect_fetch 00002000 2
4 branch 0 0
4 branch 2 1
5 retire 5
5 retire 0
5 retire 7
5 expect_fetch 00002004 5
5 expect_fetch 00002008 0
5 expect_fetch 0000200c 7
5 branch 7 1
5 idle 6 0

// ==== tb.f ====
meta_pkg.sv
fetch_config.sv
id_pool.sv
pc_gen.sv
instruction_metadata.sv
decode_stage.sv
frontend_top.sv
tb_frontend.sv

// ==== Bender.yml ====
package:
  name: frontend_meta

sources:
  - meta_pkg.sv
  - fetch_config.sv
  - id_pool.sv
  - pc_gen.sv
  - instruction_metadata.sv
  - decode_stage.sv
  - frontend_top.sv
  - target: simulation
    files:
      - tb_frontend.sv
